// ==== piano_display_pkg.sv ====
`default_nettype none

package piano_display_pkg;

  // game mode encodings from the game core
  typedef enum logic [2:0] {
    MODE_WAIT      = 3'b000,
    MODE_FREEPLAY  = 3'b100,
    MODE_AUTOPLAY  = 3'b010,
    MODE_STUDY     = 3'b001,
    MODE_ADJUST    = 3'b011,
    MODE_SELECT    = 3'b111,
    MODE_CHALLENGE = 3'b101
  } display_mode_e;

  typedef enum logic [2:0] {
    PHASE_THREE,
    PHASE_TWO,
    PHASE_ONE,
    PHASE_START,
    PHASE_RESULT
  } count_phase_e;

  localparam int NUM_DIGITS = 8;
  localparam int unsigned SCAN_TICKS = 32'd25000;
  localparam int unsigned SECOND_TICKS = 32'd100000000;

  typedef logic [7:0] glyph_t;                    // a..g then dp
  typedef glyph_t [NUM_DIGITS-1:0] frame_t;       // digit 0 in top byte

  localparam glyph_t GLYPH_DIGIT [10] = '{
    8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66,
    8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hF6
  };

  localparam glyph_t GLYPH_SEP   = 8'h02;
  localparam glyph_t GLYPH_BLANK = 8'h00;
  localparam glyph_t GLYPH_A     = 8'hEE;
  localparam glyph_t GLYPH_B     = 8'h3E;
  localparam glyph_t GLYPH_C     = 8'h9C;
  localparam glyph_t GLYPH_D     = 8'h7A;
  localparam glyph_t GLYPH_E     = 8'h9E;
  localparam glyph_t GLYPH_S     = 8'hB6;

  localparam frame_t WAIT_FRAME     = 64'hB6CE_EE0A_9E00_0000;
  localparam frame_t FREEPLAY_FRAME = 64'h8E0A_9E9E_CE1C_EE76;
  localparam frame_t RECORD_FRAME   = 64'h0A9E_1A3A_0A7A_0000;
  localparam frame_t ADJUST_FRAME   = 64'hEE7A_F07C_B61E_0000;
  localparam frame_t START_FRAME    = 64'h0000_B61E_EE0A_1E00;
  localparam frame_t THREE_FRAME    = 64'h0000_0000_00F2_0000;
  localparam frame_t TWO_FRAME      = 64'h0000_0000_DA00_0000;
  localparam frame_t ONE_FRAME      = 64'h0000_0060_0000_0000;

  localparam logic [47:0] TRACK_PREFIX = 48'h1E0A_EE9C_1E02;  // "trAct-"

  // songs 1 to 5 as HB Jn CR TS TT
  localparam logic [15:0] SONG_ABBR [5] = '{
    16'h6E3E, 16'hF02A, 16'h9C0A, 16'h1EB6, 16'h1E1E
  };
  localparam logic [15:0] RD_ABBR = 16'h0A7A;

  // indexed by account number
  localparam logic [39:0] ACCOUNT_NAME [8] = '{
    40'h6EFC_CE9E_00,   // hope
    40'hEE1C_EE2A_00,   // alan
    40'h3E3A_3E00_00,   // bob
    40'hCEEE_1E00_00,   // pat
    40'hCE9E_1E9E_0A,   // peter
    40'hF0FC_2E2A_00,   // john
    40'hEE1C_609C_9E,   // alice
    40'hEE2A_2AEE_00    // anna
  };

endpackage

`default_nettype wire

// ==== bin_to_dec_glyphs.sv ====
`timescale 1ns/1ps
`default_nettype none

module bin_to_dec_glyphs
  import piano_display_pkg::*;
(
  input  logic [9:0]   value,
  output glyph_t [2:0] digits
);

  logic [9:0]  clamped;
  logic [21:0] work;    // bcd[21:10] over binary[9:0]

  // only three digits on the display
  assign clamped = (value > 10'd999) ? 10'd999 : value;

  always_comb begin
    work = {12'd0, clamped};
    for (int i = 0; i < 10; i++) begin
      if (work[13:10] >= 4'd5) begin
        work[13:10] = work[13:10] + 4'd3;
      end
      if (work[17:14] >= 4'd5) begin
        work[17:14] = work[17:14] + 4'd3;
      end
      if (work[21:18] >= 4'd5) begin
        work[21:18] = work[21:18] + 4'd3;
      end
      work = work << 1;
    end
  end

  assign digits[2] = GLYPH_DIGIT[work[21:18]];   // hundreds
  assign digits[1] = GLYPH_DIGIT[work[17:14]];
  assign digits[0] = GLYPH_DIGIT[work[13:10]];

endmodule

`default_nettype wire

// ==== challenge_countdown.sv ====
`timescale 1ns/1ps
`default_nettype none

module challenge_countdown
  import piano_display_pkg::*;
#(
  parameter int unsigned second_ticks = SECOND_TICKS
) (
  input  logic          clk,
  input  logic          reset,
  input  display_mode_e mode,
  output count_phase_e  phase
);

  logic [31:0] tick_count;
  logic        second_done;

  assign second_done = (tick_count == second_ticks - 32'd1);

  always_ff @(posedge clk) begin
    if (reset || (mode != MODE_CHALLENGE)) begin
      tick_count <= '0;
      phase      <= PHASE_THREE;   // restart on every entry
    end else if (phase != PHASE_RESULT) begin
      if (second_done) begin
        tick_count <= '0;
        phase      <= count_phase_e'(phase + 3'd1);
      end else begin
        tick_count <= tick_count + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== frame_composer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_composer
  import piano_display_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  display_mode_e mode,
  input  logic          login,
  input  logic          record,
  input  logic [2:0]    account,
  input  logic [7:0]    song_id,
  input  count_phase_e  phase,
  input  glyph_t [2:0]  score_digits,
  input  glyph_t [2:0]  mistake_digits,
  input  glyph_t [2:0]  id_digits,
  output frame_t        frame
);

  logic        song_known;
  logic [2:0]  song_index;
  logic [15:0] song_abbr;
  logic [3:0]  score_tens;
  logic [3:0]  mistake_tens;
  glyph_t      score_grade;
  glyph_t      mistake_grade;
  frame_t      next_frame;

  // decimal value back from a digit glyph
  function automatic logic [3:0] digit_value(glyph_t g);
    logic [3:0] v;
    v = 4'd0;
    for (int k = 0; k < 10; k++) begin
      if (g == GLYPH_DIGIT[k]) begin
        v = 4'(k);
      end
    end
    return v;
  endfunction

  assign song_known = (song_id >= 8'd1) && (song_id <= 8'd5);
  assign song_index = song_id[2:0] - 3'd1;
  assign song_abbr  = song_known ? SONG_ABBR[song_index] : RD_ABBR;

  assign score_tens   = digit_value(score_digits[1]);
  assign mistake_tens = digit_value(mistake_digits[1]);

  always_comb begin
    if (score_digits[2] != GLYPH_DIGIT[0]) begin
      score_grade = GLYPH_S;           // 100 and up
    end else begin
      case (score_tens)
        4'd0:       score_grade = GLYPH_E;
        4'd1:       score_grade = GLYPH_D;
        4'd2:       score_grade = GLYPH_C;
        4'd3:       score_grade = GLYPH_B;
        4'd4, 4'd5: score_grade = GLYPH_A;
        default:    score_grade = GLYPH_S;
      endcase
    end
  end

  always_comb begin
    if (mistake_digits[2] != GLYPH_DIGIT[0]) begin
      mistake_grade = GLYPH_E;
    end else begin
      case (mistake_tens)
        4'd0:    mistake_grade = GLYPH_A;
        4'd1:    mistake_grade = GLYPH_B;
        4'd2:    mistake_grade = GLYPH_C;
        4'd3:    mistake_grade = GLYPH_D;
        default: mistake_grade = GLYPH_E;
      endcase
    end
  end

  always_comb begin
    next_frame = WAIT_FRAME;
    case (mode)
      MODE_WAIT: begin
        if (login) begin
          next_frame = {ACCOUNT_NAME[account], score_digits[1], score_digits[0], score_grade};
        end
      end
      MODE_FREEPLAY: next_frame = record ? RECORD_FRAME : FREEPLAY_FRAME;
      MODE_SELECT, MODE_AUTOPLAY: begin
        if (song_known) begin
          next_frame = {song_abbr, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK,
                        GLYPH_SEP, GLYPH_DIGIT[0], id_digits[0]};
        end else begin
          next_frame = {TRACK_PREFIX, id_digits[1], id_digits[0]};
        end
      end
      MODE_CHALLENGE: begin
        case (phase)
          PHASE_THREE: next_frame = THREE_FRAME;
          PHASE_TWO:   next_frame = TWO_FRAME;
          PHASE_ONE:   next_frame = ONE_FRAME;
          PHASE_START: next_frame = START_FRAME;
          default: begin      // results
            next_frame = {song_abbr, GLYPH_BLANK, GLYPH_SEP, mistake_digits, mistake_grade};
          end
        endcase
      end
      MODE_ADJUST: next_frame = ADJUST_FRAME;
      default:     next_frame = WAIT_FRAME;   // study falls here
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame <= WAIT_FRAME;
    end else begin
      frame <= next_frame;
    end
  end

endmodule

`default_nettype wire

// ==== digit_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module digit_scanner
  import piano_display_pkg::*;
#(
  parameter int unsigned scan_ticks = SCAN_TICKS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  frame_t                frame,
  output logic [NUM_DIGITS-1:0] tube_enable,
  output glyph_t                seg_left,
  output glyph_t                seg_right
);

  localparam int INDEX_BITS = $clog2(NUM_DIGITS);
  localparam logic [INDEX_BITS-1:0] LAST_INDEX = INDEX_BITS'(NUM_DIGITS - 1);
  localparam logic [INDEX_BITS-1:0] HALF_INDEX = INDEX_BITS'(NUM_DIGITS / 2);
  localparam logic [NUM_DIGITS-1:0] FIRST_ENABLE = {1'b1, {(NUM_DIGITS - 1){1'b0}}};

  logic [31:0]           scan_count;
  logic [INDEX_BITS-1:0] index;
  logic [INDEX_BITS-1:0] next_index;
  logic                  step;
  glyph_t                next_glyph;

  assign step       = (scan_count == scan_ticks - 32'd1);
  assign next_index = (index == LAST_INDEX) ? '0 : index + 1'b1;
  assign next_glyph = frame[LAST_INDEX - next_index];   // digit 0 is the top byte

  always_ff @(posedge clk) begin
    if (reset) begin
      scan_count  <= '0;
      index       <= '0;
      tube_enable <= FIRST_ENABLE;
      seg_left    <= '0;
      seg_right   <= '0;
    end else if (step) begin
      scan_count  <= '0;
      index       <= next_index;
      tube_enable <= FIRST_ENABLE >> next_index;
      // left half loads seg_left while the other bus keeps its glyph
      if (next_index < HALF_INDEX) begin
        seg_left <= next_glyph;
      end else begin
        seg_right <= next_glyph;
      end
    end else begin
      scan_count <= scan_count + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== tube_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tube_display_top
  import piano_display_pkg::*;
#(
  parameter int unsigned scan_ticks   = SCAN_TICKS,
  parameter int unsigned second_ticks = SECOND_TICKS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  display_mode_e         mode,
  input  logic                  login,
  input  logic                  record,
  input  logic [2:0]            account,
  input  logic [7:0]            song_id,
  input  logic [9:0]            score,
  input  logic [7:0]            mistakes,
  output logic [NUM_DIGITS-1:0] tube_enable,
  output glyph_t                seg_left,
  output glyph_t                seg_right
);

  glyph_t [2:0] score_digits;
  glyph_t [2:0] mistake_digits;
  glyph_t [2:0] id_digits;
  count_phase_e phase;
  frame_t       frame;

  bin_to_dec_glyphs u_score_dec (
    .value  (score),
    .digits (score_digits)
  );

  bin_to_dec_glyphs u_mistake_dec (
    .value  ({2'b00, mistakes}),
    .digits (mistake_digits)
  );

  bin_to_dec_glyphs u_id_dec (
    .value  ({2'b00, song_id}),
    .digits (id_digits)
  );

  challenge_countdown #(
    .second_ticks (second_ticks)
  ) challenge_countdown_inst (
    .clk   (clk),
    .reset (reset),
    .mode  (mode),
    .phase (phase)
  );

  frame_composer frame_composer_inst (
    .clk            (clk),
    .reset          (reset),
    .mode           (mode),
    .login          (login),
    .record         (record),
    .account        (account),
    .song_id        (song_id),
    .phase          (phase),
    .score_digits   (score_digits),
    .mistake_digits (mistake_digits),
    .id_digits      (id_digits),
    .frame          (frame)
  );

  digit_scanner #(
    .scan_ticks (scan_ticks)
  ) digit_scanner_inst (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .tube_enable (tube_enable),
    .seg_left    (seg_left),
    .seg_right   (seg_right)
  );

endmodule

`default_nettype wire

// ==== tube_display_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module tube_display_asserts
  import piano_display_pkg::*;
(
  input logic                  clk,
  input logic                  reset,
  input logic [NUM_DIGITS-1:0] tube_enable,
  input glyph_t                seg_left,
  input glyph_t                seg_right
);

  enable_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot(tube_enable))
    else $error("tube_enable not one-hot");

  // one position to the right, wrapping
  enable_rotates: assert property (@(posedge clk) disable iff (reset)
    (tube_enable != $past(tube_enable)) |->
      (tube_enable == {$past(tube_enable[0]), $past(tube_enable[NUM_DIGITS-1:1])}))
    else $error("tube_enable jumped");

  right_holds: assert property (@(posedge clk) disable iff (reset)
    (|tube_enable[7:4]) |-> $stable(seg_right))
    else $error("seg_right changed while left half active");

  left_holds: assert property (@(posedge clk) disable iff (reset)
    (|tube_enable[3:0]) |-> $stable(seg_left))
    else $error("seg_left changed while right half active");

endmodule

bind digit_scanner tube_display_asserts tube_display_asserts_inst (
  .clk         (clk),
  .reset       (reset),
  .tube_enable (tube_enable),
  .seg_left    (seg_left),
  .seg_right   (seg_right)
);

`default_nettype wire

// ==== tb_tube_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tube_display
  import piano_display_pkg::*;
();

  localparam int unsigned TB_SCAN_TICKS   = 4;
  localparam int unsigned TB_SECOND_TICKS = 50;
  localparam int MAX_VECTORS = 64;
  localparam int CYCLES_PER_VECTOR = 40;
  localparam int CYCLE_MARGIN = 100;

  logic                  clk;
  logic                  reset;
  display_mode_e         mode;
  logic                  login;
  logic                  record;
  logic [2:0]            account;
  logic [7:0]            song_id;
  logic [9:0]            score;
  logic [7:0]            mistakes;
  logic [NUM_DIGITS-1:0] tube_enable;
  glyph_t                seg_left;
  glyph_t                seg_right;

  // pad, mode, login, record, account, song, score, mistakes, hold, frame
  logic [127:0] vectors [0:MAX_VECTORS-1];
  int           num_vectors;
  int           cycle_limit;
  int           cycle_count;
  int           glyph_errors;
  int           enable_errors;
  int           other_errors;
  int           step_count;
  int           since_step;
  logic         reset_done;
  logic [NUM_DIGITS-1:0] prev_enable;
  event         step_ev;

  tube_display_top #(
    .scan_ticks   (TB_SCAN_TICKS),
    .second_ticks (TB_SECOND_TICKS)
  ) tube_display_top_inst (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .login       (login),
    .record      (record),
    .account     (account),
    .song_id     (song_id),
    .score       (score),
    .mistakes    (mistakes),
    .tube_enable (tube_enable),
    .seg_left    (seg_left),
    .seg_right   (seg_right)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic check_glyph(input string name, input glyph_t expected, input glyph_t actual);
    if (actual !== expected) begin
      glyph_errors++;
      $display("[ERROR] %0d ns %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_enable(input logic [NUM_DIGITS-1:0] expected,
                              input logic [NUM_DIGITS-1:0] actual);
    if (actual !== expected) begin
      enable_errors++;
      $display("[ERROR] %0d ns tube_enable expected %b got %b", $time, expected, actual);
    end
  endtask

  // drive one vector just after the clock edge and wait its hold time
  task automatic apply_vector(input logic [127:0] vec);
    @(posedge clk);
    #2;
    mode     = display_mode_e'(vec[122:120]);
    login    = vec[116];
    record   = vec[112];
    account  = vec[110:108];
    song_id  = vec[107:100];
    score    = vec[97:88];
    mistakes = vec[87:80];
    repeat (int'(vec[79:64])) @(posedge clk);
  endtask

  // read eight scan steps back into a frame glyph by glyph
  task automatic capture_frame(input frame_t expected);
    int     idx;
    glyph_t got;
    for (int s = 0; s < NUM_DIGITS; s++) begin
      @(step_ev);
      idx = step_count % NUM_DIGITS;
      if (idx < NUM_DIGITS / 2) begin
        got = seg_left;
        check_glyph($sformatf("seg_left digit %0d", idx), expected[NUM_DIGITS-1-idx], got);
      end else begin
        got = seg_right;
        check_glyph($sformatf("seg_right digit %0d", idx), expected[NUM_DIGITS-1-idx], got);
      end
    end
  endtask

  // scan monitor with its own step count
  initial begin
    step_count  = 0;
    since_step  = 0;
    prev_enable = 8'h80;
    wait (reset_done);
    @(posedge clk);
    forever begin
      @(negedge clk);
      since_step++;
      if (tube_enable !== prev_enable) begin
        step_count++;
        check_enable(8'h80 >> (step_count % NUM_DIGITS), tube_enable);
        if (since_step != TB_SCAN_TICKS) begin
          other_errors++;
          $display("scan step came after %0d cycles instead of %0d", since_step, TB_SCAN_TICKS);
        end
        since_step  = 0;
        prev_enable = tube_enable;
        -> step_ev;
      end else if (since_step > TB_SCAN_TICKS) begin
        other_errors++;
        $display("digit enable did not advance at %0d ns", $time);
        since_step = 0;
      end
    end
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run went past %0d cycles", cycle_limit);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int total_hold;
    reset         = 1'b1;
    mode          = MODE_WAIT;
    login         = 1'b0;
    record        = 1'b0;
    account       = 3'd0;
    song_id       = 8'd0;
    score         = 10'd0;
    mistakes      = 8'd0;
    reset_done    = 1'b0;
    glyph_errors  = 0;
    enable_errors = 0;
    other_errors  = 0;
    cycle_limit   = 0;
    total_hold    = 0;

    for (int i = 0; i < MAX_VECTORS; i++) begin
      vectors[i] = '1;   // all ones marks the end
    end
    $readmemh("tests.mem", vectors);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && vectors[num_vectors][127:124] != 4'hF) begin
      total_hold += int'(vectors[num_vectors][79:64]);
      num_vectors++;
    end
    if (num_vectors == 0) begin
      other_errors++;
      $display("no vectors found in tests.mem");
    end
    cycle_limit = total_hold + CYCLES_PER_VECTOR * num_vectors + CYCLE_MARGIN;

    repeat (3) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    check_enable(8'h80, tube_enable);
    check_glyph("seg_left", 8'h00, seg_left);
    check_glyph("seg_right", 8'h00, seg_right);
    reset_done = 1'b1;

    for (int v = 0; v < num_vectors; v++) begin
      apply_vector(vectors[v]);
      capture_frame(vectors[v][63:0]);
    end

    $display("glyph errors %0d, enable errors %0d, other errors %0d",
             glyph_errors, enable_errors, other_errors);
    if (glyph_errors + enable_errors + other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests.mem ====
// pad_mode_login_record_account_songid_score_mistakes_hold_frame (hex)
// frame digit 0 leftmost, hold in cycles after the inputs change
0_0_0_0_0_00_000_00_0006_B6CEEE0A9E000000
0_0_1_0_0_00_009_00_0006_6EFCCE9E00FCF69E
0_0_1_0_1_00_00A_00_0006_EE1CEE2A0060FC7A
0_0_1_0_2_00_013_00_0006_3E3A3E000060F67A
0_0_1_0_3_00_014_00_0006_CEEE1E0000DAFC9C
0_0_1_0_1_00_01D_00_0006_EE1CEE2A00DAF69C
0_0_1_0_4_00_027_00_0006_CE9E1E9E0AF2F63E
0_0_1_0_5_00_028_00_0006_F0FC2E2A0066FCEE
0_0_1_0_6_00_03B_00_0006_EE1C609C9EB6F6EE
0_0_1_0_7_00_03C_00_0006_EE2A2AEE00BEFCB6
0_0_1_0_0_00_07B_00_0006_6EFCCE9E00DAF2B6
0_4_0_0_0_00_000_00_0006_8E0A9E9ECE1CEE76
0_4_0_1_0_00_000_00_0006_0A9E1A3A0A7A0000
0_3_0_0_0_00_000_00_0006_EE7AF07CB61E0000
0_1_0_0_0_00_000_00_0006_B6CEEE0A9E000000
0_7_0_0_0_01_000_00_0006_6E3E00000002FC60
0_7_0_0_0_02_000_00_0006_F02A00000002FCDA
0_2_0_0_0_03_000_00_0006_9C0A00000002FCF2
0_2_0_0_0_04_000_00_0006_1EB600000002FC66
0_7_0_0_0_05_000_00_0006_1E1E00000002FCB6
0_7_0_0_0_25_000_00_0006_1E0AEE9C1E02F2E0
0_2_0_0_0_05_000_00_0006_1E1E00000002FCB6
0_5_0_0_0_03_000_09_0014_0000000000F20000
0_5_0_0_0_03_000_09_000A_00000000DA000000
0_5_0_0_0_03_000_09_0014_0000006000000000
0_5_0_0_0_03_000_09_0014_0000B61EEE0A1E00
0_5_0_0_0_03_000_09_0014_9C0A0002FCFCF6EE
0_5_0_0_0_03_000_27_0004_9C0A0002FCF2F67A
0_5_0_0_0_03_000_28_0004_9C0A0002FC66FC9E
0_5_0_0_0_09_000_7B_0004_0A7A000260DAF29E
0_0_0_0_0_09_000_7B_0004_B6CEEE0A9E000000
0_5_0_0_0_03_000_09_0014_0000000000F20000

// ==== filelist.f ====
piano_display_pkg.sv
bin_to_dec_glyphs.sv
challenge_countdown.sv
frame_composer.sv
digit_scanner.sv
tube_display_top.sv
tube_display_asserts.sv
tb_tube_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tube_display
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
